// File: hdl/chipsetBusPkg.sv
// Chip bus vector types, cycle-engine state encoding, register window and size constants
`default_nettype none

package chipsetBusPkg;

    ////////////////////
    // Bus vectors
    ////////////////////

    typedef logic [23:0] cpuAddrT;     // 68000 byte address, A23..A0
    typedef logic [8:0]  regOffsetT;   // Offset inside the 512-byte register block
    typedef logic [15:0] busDataT;     // One chip bus word
    typedef logic [1:0]  busSizeT;     // SIZ1:SIZ0 as driven by the CPU

    ////////////////////
    // Cycle engine
    ////////////////////

    // One code per 68000 bus state that the engine waits for.
    // The engine only moves on colour-clock edges, so each code
    // names the edge it is waiting for, not the state it is in
    typedef enum logic [1:0] {
        state2Wait = 2'b00,  // Idle, waiting for C3 fall with C1 low
        state4Wait = 2'b01,  // Strobes pending, nDbr wait states live here
        state6Wait = 2'b10,  // Waiting for C1 rise to end the cycle
        state7Done = 2'b11   // Cycle closed, rearm on the next state-4 edge
    } cycleStateT;

    ////////////////////
    // Decode constants
    ////////////////////

    // Address bits 23..9 of 0xDFF000, the custom register window.
    // The window runs up to 0xDFF1FF, so A8..A0 are the offset
    localparam logic [14:0] regWindowBase = 15'h6FF8;

    // SIZ code of a single-byte transfer.
    // 10 and 00 are both taken as a word here; no 3-byte or
    // long transfers reach the chip registers
    localparam busSizeT sizeByte = 2'b01;

endpackage

`default_nettype wire

// File: hdl/regSpaceDecode.sv
// Request hold register, chip register window decode, byte lane select and bus-error pulse
`timescale 1ns/1ps
`default_nettype none

module regSpaceDecode (
    input  wire                     CLK40,
    input  wire                     nRESET,
    input  wire                     cpuStart,     // One-cycle request pulse
    input  chipsetBusPkg::cpuAddrT  cpuAddr,
    input  wire                     cpuRnW,
    input  chipsetBusPkg::busSizeT  cpuSize,
    input  wire                     cpuAck,       // Ends the held request
    output logic                    regSpace,     // Held register cycle request
    output logic                    rnw,
    output logic                    upperLane,    // D15..D8, even byte
    output logic                    lowerLane,    // D7..D0, odd byte or word
    output logic                    decodeBerr    // One-cycle miss pulse
);

    import chipsetBusPkg::*;

    logic reqHeld;    // A request is open, from start to acknowledge
    logic windowHit;
    logic acceptReq;

    assign windowHit = (cpuAddr[23:9] == regWindowBase);  // A8..A0 are the offset
    assign acceptReq = cpuStart && !reqHeld;

    // Request bookkeeping
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            reqHeld    <= 1'b0;
            regSpace   <= 1'b0;
            decodeBerr <= 1'b0;
        end else begin
            decodeBerr <= 1'b0;              // Pulse only
            if (cpuAck) begin
                reqHeld  <= 1'b0;
                regSpace <= 1'b0;
            end else if (acceptReq) begin
                reqHeld    <= 1'b1;          // Held through the miss too, until its ack
                regSpace   <= windowHit;
                decodeBerr <= !windowHit;    // No chip cycle on a miss
            end
        end
    end

    // Direction and lanes, only meaningful while regSpace is high
    always_ff @(posedge CLK40) begin
        if (acceptReq) begin
            rnw       <= cpuRnW;
            upperLane <= !cpuAddr[0];
            lowerLane <= cpuAddr[0] || (cpuSize != sizeByte);  // Words use both lanes
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The chip bus has a single cycle in flight; a new start must wait for cpuAck
    startWhileBusy: assert property (@(posedge CLK40) disable iff (!nRESET)
        cpuStart |-> !reqHeld)
        else $error("cpuStart while a request is still held");

endmodule

`default_nettype wire

// File: hdl/chipsetRegisterCycle.sv
// C1/C3 synchronizers and the 68000-style register cycle engine with nDbr wait states
`timescale 1ns/1ps
`default_nettype none

module chipsetRegisterCycle (
    input  wire   CLK40,
    input  wire   nRESET,
    input  wire   c1,            // Colour clock phase C1, async
    input  wire   c3,            // Colour clock phase C3, async
    input  wire   nDbr,          // Agnus holds the bus while low
    input  wire   regSpace,
    input  wire   rnw,
    input  wire   upperLane,
    input  wire   lowerLane,
    output logic  nAs,
    output logic  nUds,
    output logic  nLds,
    output logic  nRegEn,
    output logic  regTa,         // One CLK40 period, on state 7 entry
    output logic  strobeActive   // Data strobes are open
);

    import chipsetBusPkg::*;

    cycleStateT  cycleState;
    logic [1:0]  c1Sync;         // [1] is the older sample
    logic [1:0]  c3Sync;
    logic        asEn;
    logic        regEnable;
    logic        strobeEn;       // Both lanes share one enable, lanes gate it
    logic        taEn;
    logic        phase2Edge;
    logic        phase4Edge;
    logic        phase6Edge;

    ////////////////////
    // Colour clock sync
    ////////////////////

    // Idle level of both phases is high, so reset there to avoid a false edge
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Sync <= 2'b11;
            c3Sync <= 2'b11;
        end else begin
            c1Sync <= {c1Sync[0], c1};
            c3Sync <= {c3Sync[0], c3};
        end
    end

    // Edge detects on the synchronized phases
    assign phase2Edge = (c1Sync == 2'b00) && (c3Sync == 2'b10);  // C3 falls, C1 low
    assign phase4Edge = (c1Sync == 2'b11) && (c3Sync == 2'b01);  // C3 rises, C1 high
    assign phase6Edge = (c1Sync == 2'b01) && (c3Sync == 2'b00);  // C1 rises, C3 low

    ////////////////////
    // Bus state machine
    ////////////////////

    // Runs on the falling edge so the synchronizer outputs are half a period old
    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cycleState <= state2Wait;
            asEn       <= 1'b0;
            regEnable  <= 1'b0;
            strobeEn   <= 1'b0;
            taEn       <= 1'b0;
        end else begin
            case (cycleState)
                state2Wait: begin
                    if (phase2Edge && regSpace) begin
                        asEn       <= 1'b1;
                        regEnable  <= 1'b1;
                        strobeEn   <= rnw;          // Reads open the strobes with nAs
                        cycleState <= state4Wait;
                    end
                end
                state4Wait: begin
                    if (phase4Edge) begin
                        strobeEn <= 1'b1;           // Writes open them here
                        if (nDbr) begin
                            cycleState <= state6Wait;
                        end                         // else wait a whole colour cycle
                    end
                end
                state6Wait: begin
                    if (phase6Edge) begin
                        taEn       <= 1'b1;
                        cycleState <= state7Done;
                    end
                end
                state7Done: begin
                    // Close the cycle at once, then idle until the phase lines up again
                    taEn      <= 1'b0;
                    asEn      <= 1'b0;
                    regEnable <= 1'b0;
                    strobeEn  <= 1'b0;
                    if (phase4Edge) begin
                        cycleState <= state2Wait;
                    end
                end
                default: cycleState <= state2Wait;
            endcase
        end
    end

    // Active-low bus outputs
    assign nAs          = !asEn;
    assign nRegEn       = !regEnable;
    assign nUds         = !(upperLane && strobeEn);
    assign nLds         = !(lowerLane && strobeEn);
    assign regTa        = taEn;
    assign strobeActive = strobeEn;

    ////////////////////
    // Checks
    ////////////////////

    // The data path sees exactly one acknowledge edge per cycle
    taSinglePulse: assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |=> !regTa)
        else $error("regTa held longer than one CLK40 period");

    // Read data is only valid while the address strobe is still down
    taInsideAs: assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |-> !nAs)
        else $error("regTa high with nAs negated");

endmodule

`default_nettype wire

// File: hdl/chipRegDataPath.sv
// Write data hold and drive enable, read data capture, CPU acknowledge and bus-error return
`timescale 1ns/1ps
`default_nettype none

module chipRegDataPath (
    input  wire                     CLK40,
    input  wire                     nRESET,
    input  wire                     regTa,         // From the negedge engine
    input  wire                     strobeActive,
    input  wire                     rnw,
    input  wire                     decodeBerr,
    input  chipsetBusPkg::busDataT  cpuWriteData,
    input  chipsetBusPkg::busDataT  chipDataIn,
    output chipsetBusPkg::busDataT  chipDataOut,
    output logic                    chipDataOe,
    output chipsetBusPkg::busDataT  cpuReadData,
    output logic                    cpuAck,
    output logic                    cpuBerr
);

    import chipsetBusPkg::*;

    busDataT writeWord;   // Frozen while the strobes are open
    busDataT readWord;

    ////////////////////
    // Data registers
    ////////////////////

    // The CPU keeps its data lines steady until the strobes open,
    // the last sample before then is what goes on the chip bus
    always_ff @(posedge CLK40) begin
        if (!strobeActive) begin
            writeWord <= cpuWriteData;
        end
        if (regTa && rnw) begin
            readWord <= chipDataIn;       // nAs is still low on this edge
        end
    end

    assign chipDataOut = writeWord;
    assign chipDataOe  = strobeActive && !rnw;   // Only a write drives the bus
    assign cpuReadData = readWord;

    ////////////////////
    // Acknowledge
    ////////////////////

    // regTa covers one posedge only, so the acknowledge is a single pulse.
    // A window miss arrives as decodeBerr and is acknowledged the same way
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cpuAck  <= 1'b0;
            cpuBerr <= 1'b0;
        end else begin
            cpuAck  <= regTa || decodeBerr;
            cpuBerr <= decodeBerr;        // Never set together with regTa
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A miss never starts a chip cycle, so a bus error can not meet regTa
    berrWithoutCycle: assert property (@(posedge CLK40) disable iff (!nRESET)
        decodeBerr |-> !strobeActive && !regTa)
        else $error("bus error raised during an active chip cycle");

endmodule

`default_nettype wire

// File: hdl/chipsetBridgeTop.sv
// Bridge top level connecting register decode, cycle engine and data path
`timescale 1ns/1ps
`default_nettype none

module chipsetBridgeTop (
    input  wire                     CLK40,
    input  wire                     nRESET,
    // CPU side
    input  wire                     cpuStart,
    input  chipsetBusPkg::cpuAddrT  cpuAddr,
    input  wire                     cpuRnW,
    input  chipsetBusPkg::busSizeT  cpuSize,
    input  chipsetBusPkg::busDataT  cpuWriteData,
    output logic                    cpuAck,
    output logic                    cpuBerr,
    output chipsetBusPkg::busDataT  cpuReadData,
    // Chip side
    input  wire                     c1,
    input  wire                     c3,
    input  wire                     nDbr,
    input  chipsetBusPkg::busDataT  chipDataIn,
    output logic                    nAs,
    output logic                    nUds,
    output logic                    nLds,
    output logic                    nRegEn,
    output chipsetBusPkg::busDataT  chipDataOut,
    output logic                    chipDataOe
);

    logic regSpace;       // Decode to engine
    logic rnw;
    logic upperLane;
    logic lowerLane;
    logic decodeBerr;     // Decode to data path
    logic regTa;          // Engine to data path
    logic strobeActive;

    regSpaceDecode regSpaceDecode_inst (
        .CLK40(CLK40), .nRESET(nRESET), .cpuStart(cpuStart), .cpuAddr(cpuAddr),
        .cpuRnW(cpuRnW), .cpuSize(cpuSize), .cpuAck(cpuAck), .regSpace(regSpace),
        .rnw(rnw), .upperLane(upperLane), .lowerLane(lowerLane), .decodeBerr(decodeBerr)
    );

    chipsetRegisterCycle chipsetRegisterCycle_inst (
        .CLK40(CLK40), .nRESET(nRESET), .c1(c1), .c3(c3), .nDbr(nDbr),
        .regSpace(regSpace), .rnw(rnw), .upperLane(upperLane), .lowerLane(lowerLane),
        .nAs(nAs), .nUds(nUds), .nLds(nLds), .nRegEn(nRegEn), .regTa(regTa),
        .strobeActive(strobeActive)
    );

    chipRegDataPath chipRegDataPath_inst (
        .CLK40(CLK40), .nRESET(nRESET), .regTa(regTa), .strobeActive(strobeActive),
        .rnw(rnw), .decodeBerr(decodeBerr), .cpuWriteData(cpuWriteData),
        .chipDataIn(chipDataIn), .chipDataOut(chipDataOut), .chipDataOe(chipDataOe),
        .cpuReadData(cpuReadData), .cpuAck(cpuAck), .cpuBerr(cpuBerr)
    );

endmodule

`default_nettype wire

// File: tests/colorClockModel.sv
// Colour clock C1/C3 quadrature source, Agnus nDbr hold model and chip register read data
`timescale 1ns/1ps
`default_nettype none

module colorClockModel (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire                       nAs,          // From the DUT chip side
    input  wire                       readCycle,    // Current request is a read
    input  chipsetBusPkg::regOffsetT  regOffset,    // Offset of the current request
    input  wire [1:0]                 dbrHold,      // Colour cycles of nDbr low per cycle
    output logic                      c1,
    output logic                      c3,
    output logic                      nDbr,
    output chipsetBusPkg::busDataT    chipDataIn
);

    import chipsetBusPkg::*;

    logic [3:0] phaseCount;   // 12 CLK40 per colour cycle
    logic [3:0] nextCount;
    logic [5:0] holdLeft;     // Remaining nDbr low cycles
    logic       prevNAs;

    initial begin
        c1         = 1'b1;
        c3         = 1'b1;
        nDbr       = 1'b1;
        chipDataIn = '0;
    end

    assign nextCount = (phaseCount == 4'd11) ? 4'd0 : phaseCount + 4'd1;

    ////////////////////
    // Quadrature
    ////////////////////

    // {c1,c3} steps 11, 01, 00, 10, one quarter every 3 CLK40
    always @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            phaseCount <= 4'd0;
            c1         <= 1'b1;
            c3         <= 1'b1;
        end else begin
            phaseCount <= nextCount;
            if (nextCount < 4'd3)       {c1, c3} <= 2'b11;
            else if (nextCount < 4'd6)  {c1, c3} <= 2'b01;
            else if (nextCount < 4'd9)  {c1, c3} <= 2'b00;  // C3 fall here, state 2
            else                        {c1, c3} <= 2'b10;  // C1 rise here, state 6
        end
    end

    ////////////////////
    // Agnus and registers
    ////////////////////

    always @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            prevNAs    <= 1'b1;
            holdLeft   <= 6'd0;
            nDbr       <= 1'b1;
            chipDataIn <= '0;
        end else begin
            prevNAs <= nAs;
            if (prevNAs && !nAs && dbrHold != 2'd0) begin
                holdLeft <= {4'b0, dbrHold} * 6'd12 - 6'd1;   // Whole colour cycles
                nDbr     <= 1'b0;
            end else if (holdLeft != 6'd0) begin
                holdLeft <= holdLeft - 6'd1;
            end else begin
                nDbr <= 1'b1;
            end
            // Register contents are the offset with a fixed pattern
            chipDataIn <= (!nAs && readCycle) ? ({7'b0, regOffset} ^ 16'hA5C3) : 16'h0000;
        end
    end

endmodule

`default_nettype wire

// File: tests/chipsetBridgeTb.sv
// Bridge testbench with stimulus table, clock and reset, cycle monitor, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module chipsetBridgeTb;

    import chipsetBusPkg::*;

    typedef struct packed {
        cpuAddrT addr;
        logic    rnw;
        busSizeT size;
        busDataT wdata;
        logic [1:0] dbrHold;  // Colour cycles of nDbr low
        logic    expBerr;
        logic    expUds;      // Strobe expected low at some point
        logic    expLds;
    } stimEntryT;

    localparam int numTests      = 9;
    localparam int resetCycles   = 8;
    localparam int timeoutCycles = numTests * 80 + resetCycles;

    logic CLK40, nRESET, cpuStart, cpuRnW, cpuAck, cpuBerr;
    logic nAs, nUds, nLds, nRegEn, chipDataOe, c1, c3, nDbr;
    logic readCycle;
    logic [1:0] dbrHold;
    cpuAddrT   cpuAddr;
    busSizeT   cpuSize;
    busDataT   cpuWriteData, cpuReadData, chipDataIn, chipDataOut;
    regOffsetT regOffset;
    stimEntryT stimTable [numTests];
    int  cycleCount;
    bit  sawAs, sawRegEn, sawUds, sawLds, sawDbrLow, seenState4;  // Per-cycle observations
    logic prevC3;
    integer seed;

    chipsetBridgeTop chipsetBridgeTop_inst (.*);

    colorClockModel colorClockModel_inst (
        .CLK40(CLK40), .nRESET(nRESET), .nAs(nAs), .readCycle(readCycle),
        .regOffset(regOffset), .dbrHold(dbrHold), .c1(c1), .c3(c3), .nDbr(nDbr),
        .chipDataIn(chipDataIn)
    );

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;   // 25 MHz
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareWord(input string sigName, input busDataT got, input busDataT exp);
        if (got !== exp)
            stopOnError($sformatf("FAILED at %0t: %s is %h, expected %h",
                                  $time, sigName, got, exp));
    endtask

    task automatic compareBit(input string sigName, input logic got, input logic exp);
        if (got !== exp)
            stopOnError($sformatf("FAILED at %0t: %s is %b, expected %b",
                                  $time, sigName, got, exp));
    endtask

    // Flags gathered over a whole bus cycle
    task automatic expectSeen(input string what, input bit seen, input bit exp);
        if (seen != exp)
            stopOnError($sformatf("FAILED at %0t: %s seen %0d, expected %0d",
                                  $time, what, seen, exp));
    endtask

    function automatic stimEntryT makeEntry(input cpuAddrT addr, input logic rnw,
            input busSizeT size, input busDataT wdata, input logic expBerr);
        stimEntryT e;
        e.addr    = addr;
        e.rnw     = rnw;
        e.size    = size;
        e.wdata   = wdata;
        e.dbrHold = 2'd0;
        e.expBerr = expBerr;
        e.expUds  = !expBerr && !addr[0];                                   // Even byte lane
        e.expLds  = !expBerr && (addr[0] || size == 2'b10 || size == 2'b00);  // Odd byte or word
        return e;
    endfunction

    // Engine outputs move on the falling edge so the rising edge sees them settled
    always @(posedge CLK40) begin
        if (nRESET) begin
            if (!nAs) sawAs = 1'b1;
            if (!nRegEn) sawRegEn = 1'b1;
            if (!nUds) sawUds = 1'b1;
            if (!nLds) sawLds = 1'b1;
            if (!nDbr) sawDbrLow = 1'b1;
            if (!cpuRnW && !nAs && !seenState4 && (!nUds || !nLds))
                stopOnError("Write strobe went low before the state-4 colour edge");
            if (!cpuRnW && (!nUds || !nLds)) begin
                compareBit("chipDataOe", chipDataOe, 1'b1);
                compareWord("chipDataOut", chipDataOut, cpuWriteData);
            end else begin
                compareBit("chipDataOe", chipDataOe, 1'b0);   // Reads and idle leave the bus
            end
            if (nAs) seenState4 = 1'b0;
            else if (c1 && c3 && !prevC3) seenState4 = 1'b1;  // Raw C3 rise with C1 high
            prevC3 = c3;
        end
    end

    always @(posedge CLK40) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutCycles)
            stopOnError("Timeout: the request table did not finish in time");
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        stimEntryT e;
        cycleCount = 0;
        seed = 92;
        nRESET = 1'b0;
        cpuStart = 1'b0;
        cpuAddr = '0;
        cpuRnW = 1'b1;
        cpuSize = 2'b10;
        cpuWriteData = '0;
        readCycle = 1'b0;
        regOffset = '0;
        dbrHold = 2'd0;
        prevC3 = 1'b1;
        stimTable[0] = makeEntry(24'hDFF006, 1'b1, 2'b10, 16'h0000, 1'b0);  // Word read
        stimTable[1] = makeEntry(24'hDFF180, 1'b0, 2'b00, 16'h0F0A, 1'b0);  // Word write
        stimTable[2] = makeEntry(24'hDFF00A, 1'b1, 2'b01, 16'h0000, 1'b0);  // Byte read even
        stimTable[3] = makeEntry(24'hDFF00B, 1'b1, 2'b01, 16'h0000, 1'b0);  // Byte read odd
        stimTable[4] = makeEntry(24'hDFF09A, 1'b0, 2'b01, 16'hC0C0, 1'b0);  // Byte write even
        stimTable[5] = makeEntry(24'hDFF09B, 1'b0, 2'b01, 16'h3C5A, 1'b0);  // Byte write odd
        stimTable[6] = makeEntry(24'hC00000, 1'b1, 2'b10, 16'h0000, 1'b1);  // Slow RAM miss
        stimTable[7] = makeEntry(24'hDFF200, 1'b0, 2'b10, 16'h1234, 1'b1);  // Just past window
        stimTable[8] = makeEntry(24'hDFF1FE, 1'b1, 2'b10, 16'h0000, 1'b0);  // Top of window
        foreach (stimTable[i])
            if (!stimTable[i].expBerr) stimTable[i].dbrHold = $unsigned($random(seed)) % 4;

        repeat (resetCycles) @(posedge CLK40);
        nRESET <= 1'b1;
        @(negedge CLK40);
        compareBit("nAs", nAs, 1'b1);
        compareBit("nUds", nUds, 1'b1);
        compareBit("nLds", nLds, 1'b1);
        compareBit("nRegEn", nRegEn, 1'b1);
        compareBit("cpuAck", cpuAck, 1'b0);
        compareBit("cpuBerr", cpuBerr, 1'b0);
        compareBit("chipDataOe", chipDataOe, 1'b0);

        for (int idx = 0; idx < numTests; idx++) begin
            e = stimTable[idx];
            {sawAs, sawRegEn, sawUds, sawLds, sawDbrLow} = 5'b0;
            @(posedge CLK40);
            cpuStart     <= 1'b1;
            cpuAddr      <= e.addr;
            cpuRnW       <= e.rnw;
            cpuSize      <= e.size;
            cpuWriteData <= e.wdata;
            readCycle    <= e.rnw;
            regOffset    <= e.addr[8:0];
            dbrHold      <= e.dbrHold;
            @(posedge CLK40);
            cpuStart <= 1'b0;
            do @(negedge CLK40); while (!cpuAck);   // Timeout covers a lost ack
            compareBit("cpuBerr", cpuBerr, e.expBerr);
            if (e.rnw && !e.expBerr)
                compareWord("cpuReadData", cpuReadData, {7'b0, e.addr[8:0]} ^ 16'hA5C3);
            expectSeen("nAs low", sawAs, !e.expBerr);
            expectSeen("nRegEn low", sawRegEn, !e.expBerr);
            expectSeen("nUds low", sawUds, e.expUds);
            expectSeen("nLds low", sawLds, e.expLds);
            expectSeen("nDbr low", sawDbrLow, e.dbrHold != 2'd0);
            compareBit("nDbr", nDbr, 1'b1);   // Ack only after Agnus lets go
            @(negedge CLK40);
            compareBit("cpuAck", cpuAck, 1'b0);
            compareBit("nAs", nAs, 1'b1);       // Cycle closed before the next request
            compareBit("nRegEn", nRegEn, 1'b1);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/chipsetBusPkg.sv
hdl/regSpaceDecode.sv
hdl/chipsetRegisterCycle.sv
hdl/chipRegDataPath.sv
hdl/chipsetBridgeTop.sv
tests/colorClockModel.sv
tests/chipsetBridgeTb.sv
